// ==== rtl/csma_consts.svh ====
// widths follow the 802.11 MAC fields; all times count the 1 us tsf tick

`ifndef CSMA_CONSTS_SVH
`define CSMA_CONSTS_SVH

// timer and counter widths
`define CSMA_US_W   12
`define CSMA_SLOT_W 10
`define CSMA_NAV_W  15
`define CSMA_CW_W   4

// backoff timer holds slot count times slot time
`define CSMA_BO_W (`CSMA_SLOT_W + `CSMA_US_W)

// frame field widths
`define CSMA_MAC_W 48
`define CSMA_DUR_W 16

// slot LFSR, xnor feedback
`define CSMA_LFSR_W    32
`define CSMA_LFSR_INIT 32'h1020_f0cb
`define CSMA_LFSR_TAPS 32'h8020_0003 // bits 31, 21, 1 and 0

// longest ACK airtime added on top of the EIFS
`define CSMA_LONGEST_ACK_US 44

// contention window exponent ceiling
`define CSMA_MAX_CW_EXP 10

`endif

// ==== rtl/timing_pkg.sv ====
// microsecond and slot types of the access engine; a slot count never exceeds 1023

`include "csma_consts.svh"

package timing_pkg;

    // microsecond counts for sifs, slot and the advance values
    typedef logic [`CSMA_US_W-1:0] usec_t;

    // number of backoff slots
    typedef logic [`CSMA_SLOT_W-1:0] slot_cnt_t;

    // contention window exponent
    typedef logic [`CSMA_CW_W-1:0] cw_exp_t;

    // deferral and backoff states
    typedef enum logic [2:0] {
        idle       = 3'd0,
        ch_busy    = 3'd1,
        wait_high  = 3'd2, // deferral only, no random slots
        wait_retry = 3'd3, // deferral ahead of random backoff
        run        = 3'd4,
        suspend    = 3'd5,
        wait_own   = 3'd6  // access granted, waiting for own tx
    } backoff_state_t;

endpackage

// ==== rtl/frame_pkg.sv ====
// received frame field types; only duration values below 32768 ever reach the NAV

`include "csma_consts.svh"

package frame_pkg;

    // station address
    typedef logic [`CSMA_MAC_W-1:0] mac_addr_t;

    // duration/id field as received, bit 15 set means id
    typedef logic [`CSMA_DUR_W-1:0] duration_t;

    // NAV in microseconds
    typedef logic [`CSMA_NAV_W-1:0] nav_t;

    // per frame NAV decision
    typedef enum logic [1:0] {
        nav_idle     = 2'd0,
        nav_wait_dur = 2'd1,
        nav_check_ra = 2'd2,
        nav_update   = 2'd3
    } nav_state_t;

endpackage

// ==== rtl/nav_tracker.sv ====
// NAV is set only from frames to other stations with a valid FCS; medium_idle is combinational on ch_idle

`include "csma_consts.svh"

module nav_tracker (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tsf_tick,
    input  logic                hdr_strobe,
    input  logic                hdr_valid,
    input  logic                fc_valid,
    input  frame_pkg::duration_t duration,
    input  logic                addr1_valid,
    input  frame_pkg::mac_addr_t addr1,
    input  frame_pkg::mac_addr_t self_mac_addr,
    input  logic                fcs_valid,
    input  logic                nav_enable,
    input  logic                ch_idle,
    output frame_pkg::nav_t     nav,
    output logic                medium_idle
);

    import frame_pkg::*;

    nav_state_t nav_state;
    logic       nav_set;   // one cycle load request
    nav_t       nav_new;   // candidate value from the frame

    // virtual and physical carrier sense combined
    assign medium_idle = ch_idle && (!nav_enable || (nav == '0));

    // per frame decision
    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav_state <= nav_idle;
            nav_set   <= 1'b0;
        end else begin
            nav_set <= 1'b0;
            if (hdr_strobe) begin
                // new header restarts the machine even if the last FCS never came
                nav_state <= hdr_valid ? nav_wait_dur : nav_idle;
            end else begin
                case (nav_state)
                    nav_idle: begin
                        nav_state <= nav_idle;
                    end
                    nav_wait_dur: begin
                        if (fc_valid && !duration[`CSMA_DUR_W-1]) begin
                            nav_state <= nav_check_ra;
                        end
                    end
                    nav_check_ra: begin
                        // frames to us leave the NAV alone
                        if (addr1_valid && (addr1 != self_mac_addr)) begin
                            nav_state <= nav_update;
                        end
                    end
                    nav_update: begin
                        if (fcs_valid) begin
                            nav_set   <= 1'b1;
                            nav_state <= nav_idle;
                        end
                    end
                    default: begin
                        nav_state <= nav_idle;
                    end
                endcase
            end
        end
    end

    // duration captured alongside the load request
    always_ff @(posedge clk) begin
        if ((nav_state == nav_update) && fcs_valid) begin
            nav_new <= duration[`CSMA_NAV_W-1:0];
        end
    end

    // NAV keeps the larger value, then counts down per us
    always_ff @(posedge clk) begin
        if (!rstn) begin
            nav <= '0;
        end else if (nav_set) begin
            nav <= (nav_new > nav) ? nav_new : nav;
        end else if (tsf_tick && (nav != '0)) begin
            nav <= nav - nav_t'(1);
        end
    end

endmodule

// ==== rtl/slot_draw.sv ====
// LFSR advances only on draw_req; num_slot follows cw_exp combinationally and stays below 2**cw_exp

`include "csma_consts.svh"

module slot_draw (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 draw_req,
    input  timing_pkg::cw_exp_t  cw_exp,
    output timing_pkg::slot_cnt_t num_slot
);

    import timing_pkg::*;

    logic [`CSMA_LFSR_W-1:0] lfsr;
    logic                    feedback;
    cw_exp_t                 exp_sat;
    slot_cnt_t               mask;     // low exp_sat bits set

    // xnor of the tapped bits
    assign feedback = ~^(lfsr & `CSMA_LFSR_TAPS);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lfsr <= `CSMA_LFSR_INIT;
        end else if (draw_req) begin
            lfsr <= {lfsr[`CSMA_LFSR_W-2:0], feedback};
        end
    end

    // exponent saturates at the largest window
    assign exp_sat = (cw_exp > cw_exp_t'(`CSMA_MAX_CW_EXP)) ?
                     cw_exp_t'(`CSMA_MAX_CW_EXP) : cw_exp;

    assign mask = ~({`CSMA_SLOT_W{1'b1}} << exp_sat); // zero for exponent 0

    // low bits of the LFSR inside the window
    assign num_slot = lfsr[`CSMA_SLOT_W-1:0] & mask;

endmodule

// ==== rtl/backoff_fsm.sv ====
// triggers are taken only in idle; deferral and backoff counts saturate at zero and wrap above 12/22 bits

`include "csma_consts.svh"

module backoff_fsm (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  tsf_tick,
    input  logic                  medium_idle,
    input  logic                  fcs_strobe,
    input  logic                  fcs_valid,
    input  logic                  difs_enable,
    input  logic                  eifs_enable,
    input  timing_pkg::usec_t     sifs_time,
    input  timing_pkg::usec_t     slot_time,
    input  timing_pkg::usec_t     difs_advance,
    input  timing_pkg::usec_t     backoff_advance,
    input  logic                  high_trigger,
    input  logic                  retrans_trigger,
    input  logic                  tx_ongoing,
    input  logic                  ack_tx,
    input  timing_pkg::slot_cnt_t num_slot,
    input  timing_pkg::cw_exp_t   cw_exp,
    output logic                  draw_req,
    output logic                  backoff_done,
    output timing_pkg::slot_cnt_t slot_log,
    output timing_pkg::cw_exp_t   cw_log
);

    import timing_pkg::*;

    backoff_state_t         state;
    usec_t                  wait_timer;  // deferral countdown
    logic [`CSMA_BO_W-1:0]  bo_timer;    // random backoff countdown
    logic                   last_rx_fail;

    usec_t                  difs_full;
    usec_t                  difs_time;
    usec_t                  eifs_full;
    usec_t                  eifs_time;
    usec_t                  defer_time;
    logic [`CSMA_BO_W-1:0]  slot_prod;
    logic [`CSMA_BO_W-1:0]  bo_adv_w;
    logic [`CSMA_BO_W-1:0]  bo_load;

    // DIFS before and after the advance
    assign difs_full = difs_enable ? (sifs_time + slot_time + slot_time) : '0;
    assign difs_time = (difs_full > difs_advance) ? (difs_full - difs_advance) : '0;

    // EIFS after a failed reception
    assign eifs_full = sifs_time + difs_full + usec_t'(`CSMA_LONGEST_ACK_US);
    assign eifs_time = (eifs_full > difs_advance) ? (eifs_full - difs_advance) : '0;

    assign defer_time = (eifs_enable && last_rx_fail) ? eifs_time : difs_time;

    // slots times slot time, less the advance
    assign slot_prod = {{`CSMA_US_W{1'b0}}, num_slot} * {{`CSMA_SLOT_W{1'b0}}, slot_time};
    assign bo_adv_w  = {{`CSMA_SLOT_W{1'b0}}, backoff_advance};
    assign bo_load   = (slot_prod > bo_adv_w) ? (slot_prod - bo_adv_w) : '0;

    assign backoff_done = (state == wait_own);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= idle;
            wait_timer   <= '0;
            bo_timer     <= '0;
            last_rx_fail <= 1'b0;
            draw_req     <= 1'b0;
            slot_log     <= '0;
            cw_log       <= '0;
        end else begin
            draw_req <= 1'b0;
            if (fcs_strobe) begin
                last_rx_fail <= ~fcs_valid;
            end

            case (state)
                idle: begin
                    if (high_trigger) begin
                        slot_log <= '0; // no random slots on this path
                        cw_log   <= '0;
                    end
                    if (high_trigger || retrans_trigger) begin
                        wait_timer <= defer_time;
                        if (!medium_idle) begin
                            state <= ch_busy;
                        end else if (high_trigger) begin
                            state <= wait_high;
                        end else begin
                            state <= wait_retry;
                        end
                    end
                end

                ch_busy: begin
                    // full deferral again once the medium frees up
                    if (medium_idle) begin
                        wait_timer <= defer_time;
                        state      <= wait_retry;
                    end
                end

                wait_high: begin
                    if (tsf_tick && (wait_timer != '0)) begin
                        wait_timer <= wait_timer - usec_t'(1);
                    end
                    if (!medium_idle) begin
                        state <= ch_busy;
                    end else if (wait_timer == '0) begin
                        state <= wait_own;
                    end
                end

                wait_retry: begin
                    if (tsf_tick && (wait_timer != '0)) begin
                        wait_timer <= wait_timer - usec_t'(1);
                    end
                    // fresh slot count ready well before the deferral ends
                    if (tsf_tick && (wait_timer == usec_t'(2))) begin
                        draw_req <= 1'b1;
                    end
                    if (!medium_idle) begin
                        state <= ch_busy;
                    end else if (wait_timer == '0) begin
                        bo_timer <= bo_load;
                        slot_log <= num_slot;
                        cw_log   <= cw_exp;
                        state    <= run;
                    end
                end

                run: begin
                    if (!medium_idle) begin
                        state <= (bo_timer == '0) ? ch_busy : suspend;
                    end else if (bo_timer == '0) begin
                        state <= wait_own;
                    end else if (tsf_tick) begin
                        bo_timer <= bo_timer - {{(`CSMA_BO_W-1){1'b0}}, 1'b1};
                    end
                end

                suspend: begin
                    if (medium_idle) begin
                        state <= run; // remaining count kept
                    end
                end

                wait_own: begin
                    if (tx_ongoing) begin
                        state <= ack_tx ? ch_busy : idle;
                    end
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== rtl/csma_ca.sv ====
// channel access engine top; cw_exp is sampled when the random backoff starts

module csma_ca (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  tsf_tick,        // 1 us strobe
    input  logic                  hdr_strobe,
    input  logic                  hdr_valid,
    input  logic                  fc_valid,
    input  frame_pkg::duration_t  duration,
    input  logic                  addr1_valid,
    input  frame_pkg::mac_addr_t  addr1,
    input  frame_pkg::mac_addr_t  self_mac_addr,
    input  logic                  fcs_strobe,
    input  logic                  fcs_valid,
    input  logic                  nav_enable,
    input  logic                  ch_idle,
    input  logic                  difs_enable,
    input  logic                  eifs_enable,
    input  timing_pkg::usec_t     sifs_time,
    input  timing_pkg::usec_t     slot_time,
    input  timing_pkg::usec_t     difs_advance,
    input  timing_pkg::usec_t     backoff_advance,
    input  logic                  high_trigger,
    input  logic                  retrans_trigger,
    input  logic                  tx_ongoing,
    input  logic                  ack_tx,
    input  timing_pkg::cw_exp_t   cw_exp,
    output frame_pkg::nav_t       nav,
    output logic                  medium_idle,
    output logic                  backoff_done,
    output timing_pkg::slot_cnt_t slot_log,
    output timing_pkg::cw_exp_t   cw_log
);

    import timing_pkg::*;

    logic      draw_req;
    slot_cnt_t num_slot;

    // carrier sense with NAV
    nav_tracker nav_tracker_inst (
        .clk           (clk),
        .rstn          (rstn),
        .tsf_tick      (tsf_tick),
        .hdr_strobe    (hdr_strobe),
        .hdr_valid     (hdr_valid),
        .fc_valid      (fc_valid),
        .duration      (duration),
        .addr1_valid   (addr1_valid),
        .addr1         (addr1),
        .self_mac_addr (self_mac_addr),
        .fcs_valid     (fcs_valid),
        .nav_enable    (nav_enable),
        .ch_idle       (ch_idle),
        .nav           (nav),
        .medium_idle   (medium_idle)
    );

    slot_draw slot_draw_inst (
        .clk      (clk),
        .rstn     (rstn),
        .draw_req (draw_req),
        .cw_exp   (cw_exp),
        .num_slot (num_slot)
    );

    backoff_fsm backoff_fsm_inst (
        .clk             (clk),
        .rstn            (rstn),
        .tsf_tick        (tsf_tick),
        .medium_idle     (medium_idle),
        .fcs_strobe      (fcs_strobe),
        .fcs_valid       (fcs_valid),
        .difs_enable     (difs_enable),
        .eifs_enable     (eifs_enable),
        .sifs_time       (sifs_time),
        .slot_time       (slot_time),
        .difs_advance    (difs_advance),
        .backoff_advance (backoff_advance),
        .high_trigger    (high_trigger),
        .retrans_trigger (retrans_trigger),
        .tx_ongoing      (tx_ongoing),
        .ack_tx          (ack_tx),
        .num_slot        (num_slot),
        .cw_exp          (cw_exp),
        .draw_req        (draw_req),
        .backoff_done    (backoff_done),
        .slot_log        (slot_log),
        .cw_log          (cw_log)
    );

endmodule

// ==== tests/csma_checks.sv ====
// checks sampled 1 ns after each rising edge; triggers are assumed to arrive only while the DUT is idle

`include "csma_consts.svh"

module csma_checks (
    input logic                  clk,
    input logic                  rstn,
    input logic                  tsf_tick,
    input logic                  hdr_strobe,
    input logic                  fcs_strobe,
    input logic                  fcs_valid,
    input logic                  difs_enable,
    input logic                  eifs_enable,
    input timing_pkg::usec_t     sifs_time,
    input timing_pkg::usec_t     slot_time,
    input timing_pkg::usec_t     difs_advance,
    input timing_pkg::usec_t     backoff_advance,
    input logic                  high_trigger,
    input logic                  retrans_trigger,
    input logic                  tx_ongoing,
    input timing_pkg::cw_exp_t   cw_exp,
    input frame_pkg::nav_t       nav,
    input logic                  medium_idle,
    input logic                  backoff_done,
    input timing_pkg::slot_cnt_t slot_log,
    input timing_pkg::cw_exp_t   cw_log
);

    timeunit 1ns;
    timeprecision 1ps;

    import frame_pkg::*;

    int   err_cnt = 0;
    int   idle_ticks;  // idle-medium ticks since the trigger
    int   defer_ref;
    int   total_ref;
    int   bo_ref;
    logic armed;
    logic arm_high;
    logic fail_ref;    // last reception had a bad FCS
    logic done_prev;
    logic fcs_prev;
    logic seen_hdr;
    logic seen_trig;
    nav_t nav_prev;

    task automatic report_mismatch(input string name, input int exp_v, input int got_v);
        $display("Fail %0t %s exp=%0d got=%0d", $time, name, exp_v, got_v);
        err_cnt++;
    endtask

    // DIFS or EIFS per the access rules
    function automatic int expected_defer();
        int full;
        int raw;
        full = difs_enable ? int'(sifs_time) + 2 * int'(slot_time) : 0;
        if (eifs_enable && fail_ref) begin
            raw = int'(sifs_time) + full + `CSMA_LONGEST_ACK_US - int'(difs_advance);
        end else begin
            raw = full - int'(difs_advance);
        end
        return (raw < 0) ? 0 : raw;
    endfunction

    always @(posedge clk) begin
        #1;
        if (!rstn) begin
            armed     = 1'b0;
            arm_high  = 1'b0;
            fail_ref  = 1'b0;
            done_prev = 1'b0;
            fcs_prev  = 1'b0;
            seen_hdr  = 1'b0;
            seen_trig = 1'b0;
            nav_prev  = '0;
            idle_ticks = 0;
        end else begin
            if (!seen_hdr) assert (nav == '0) else report_mismatch("nav", 0, nav);
            if (!seen_trig) assert (!backoff_done) else report_mismatch("backoff_done", 0, 1);
            // countdown by one per tick, skipped where a load may land
            if (!fcs_prev) begin
                if (tsf_tick && nav_prev != '0) begin
                    assert (nav == nav_prev - 1) else report_mismatch("nav", nav_prev - 1, nav);
                end else begin
                    assert (nav == nav_prev) else report_mismatch("nav", nav_prev, nav);
                end
            end
            if (done_prev && tx_ongoing) begin
                assert (!backoff_done) else report_mismatch("backoff_done", 0, 1);
            end
            if (backoff_done && !done_prev) begin
                assert (medium_idle) else report_mismatch("medium_idle", 1, 0);
                if (armed) begin
                    bo_ref = int'(slot_log) * int'(slot_time) - int'(backoff_advance);
                    if (bo_ref < 0) bo_ref = 0;
                    total_ref = arm_high ? defer_ref : defer_ref + bo_ref;
                    assert (idle_ticks >= total_ref - 1 && idle_ticks <= total_ref + 1)
                        else report_mismatch("idle_ticks", total_ref, idle_ticks);
                    if (arm_high) begin
                        assert (slot_log == '0) else report_mismatch("slot_log", 0, slot_log);
                    end else begin
                        assert (int'(slot_log) < (1 << cw_exp))
                            else report_mismatch("slot_log", (1 << cw_exp) - 1, slot_log);
                        assert (cw_log == cw_exp) else report_mismatch("cw_log", cw_exp, cw_log);
                    end
                    armed = 1'b0;
                end else begin
                    $display("backoff_done rose at %0t without any trigger", $time);
                    err_cnt++;
                end
            end else if (armed && tsf_tick && medium_idle) begin
                idle_ticks++;
            end
            if (!armed && !backoff_done && (high_trigger || retrans_trigger)) begin
                armed      = 1'b1;
                arm_high   = high_trigger;
                defer_ref  = expected_defer();
                idle_ticks = 0;
                seen_trig  = 1'b1;
            end
            if (hdr_strobe) seen_hdr = 1'b1;
            if (fcs_strobe) fail_ref = !fcs_valid;
            nav_prev  = nav;
            done_prev = backoff_done;
            fcs_prev  = fcs_valid;
        end
    end

endmodule

// ==== tests/tb_csma_ca.sv ====
// tick every 5 clocks stands in for the 1 us tsf strobe; nav_enable stays on for the whole run

module tb_csma_ca;

    timeunit 1ns;
    timeprecision 1ps;

    import timing_pkg::*;
    import frame_pkg::*;

    localparam int TOTAL_TICKS = 2000; // sum of scenario budgets
    localparam int DEFER = 10 + 2 * 9 - 2;

    logic clk, rstn, tsf_tick, hdr_strobe, hdr_valid, fc_valid, addr1_valid;
    logic fcs_strobe, fcs_valid, nav_enable, ch_idle, difs_enable, eifs_enable;
    logic high_trigger, retrans_trigger, tx_ongoing, ack_tx;
    logic medium_idle, backoff_done;
    duration_t duration;
    duration_t dur;
    mac_addr_t addr1, self_mac_addr;
    usec_t sifs_time, slot_time, difs_advance, backoff_advance;
    cw_exp_t cw_exp, cw_log;
    slot_cnt_t slot_log;
    nav_t nav;
    int tick_cnt = 0;
    int tb_err = 0;

    csma_ca csma_ca_inst (.*);

    csma_checks csma_checks_inst (.*);

    always #10 clk = ~clk;

    always @(negedge clk) begin
        tsf_tick <= (tick_cnt == 4);
        tick_cnt <= (tick_cnt == 4) ? 0 : tick_cnt + 1;
    end

    task automatic note_value_error(input string name, input int exp_v, input int got_v);
        $display("Fail %0t %s exp=%0d got=%0d", $time, name, exp_v, got_v);
        tb_err++;
    endtask

    task automatic send_frame(input duration_t d, input logic to_self, input logic fcs_ok);
        @(negedge clk) hdr_strobe = 1'b1;
        hdr_valid = 1'b1;
        @(negedge clk) hdr_strobe = 1'b0;
        fc_valid = 1'b1;
        duration = d;
        @(negedge clk) fc_valid = 1'b0;
        addr1_valid = 1'b1;
        addr1 = to_self ? self_mac_addr : 48'h0200_0000_00aa;
        @(negedge clk) addr1_valid = 1'b0;
        fcs_strobe = 1'b1;
        fcs_valid = fcs_ok;
        @(negedge clk) fcs_strobe = 1'b0;
        fcs_valid = 1'b0;
    endtask

    // one-cycle pulse helpers
    task automatic pulse_high();
        @(negedge clk) high_trigger = 1'b1;
        @(negedge clk) high_trigger = 1'b0;
    endtask

    task automatic pulse_retrans();
        @(negedge clk) retrans_trigger = 1'b1;
        @(negedge clk) retrans_trigger = 1'b0;
    endtask

    task automatic start_tx();
        @(negedge clk) tx_ongoing = 1'b1;
        @(negedge clk) tx_ongoing = 1'b0;
        assert (!backoff_done) else note_value_error("backoff_done", 0, 1);
    endtask

    task automatic wait_done(input int max_ticks);
        int cyc;
        cyc = 0;
        while (!backoff_done && cyc < max_ticks * 5) begin
            @(negedge clk);
            cyc++;
        end
        if (!backoff_done) begin
            $display("backoff_done did not rise within %0d ticks", max_ticks);
            tb_err++;
        end
    endtask

    task automatic wait_tick_edges(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (tsf_tick) seen++;
        end
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'ha5571442));
        clk = 0; rstn = 0; tsf_tick = 0; hdr_strobe = 0; hdr_valid = 0;
        fc_valid = 0; addr1_valid = 0; fcs_strobe = 0; fcs_valid = 0;
        nav_enable = 1; ch_idle = 1; difs_enable = 1; eifs_enable = 1;
        high_trigger = 0; retrans_trigger = 0; tx_ongoing = 0; ack_tx = 0;
        duration = '0; addr1 = '0; self_mac_addr = 48'h0200_0000_0001;
        sifs_time = 10; slot_time = 9; difs_advance = 2; backoff_advance = 3;
        cw_exp = 4;
        repeat (3) @(negedge clk);
        rstn = 1;
        repeat (10) @(negedge clk);
        // NAV from a frame to another station, then one to us
        dur = duration_t'(20 + $urandom % 150);
        send_frame(dur, 1'b0, 1'b1);
        @(negedge clk);
        assert (nav == dur || nav == dur - 1) else note_value_error("nav", dur, nav);
        wait_tick_edges(int'(dur) + 2);
        assert (nav == '0) else note_value_error("nav", 0, nav);
        send_frame(dur, 1'b1, 1'b1);
        repeat (3) @(negedge clk);
        assert (nav == '0) else note_value_error("nav", 0, nav);
        // high priority access
        pulse_high();
        wait_done(200);
        start_tx();
        // random backoff
        cw_exp = cw_exp_t'(3 + $urandom % 4);
        pulse_retrans();
        wait_done(800);
        start_tx();
        // backoff suspended by a busy medium
        cw_exp = 6;
        pulse_retrans();
        wait_tick_edges(DEFER + 2);
        repeat (2) @(negedge clk);
        if (!backoff_done) begin
            ch_idle = 1'b0;
            repeat (100) @(negedge clk);
            assert (!backoff_done) else note_value_error("backoff_done", 0, 1);
            ch_idle = 1'b1;
        end
        wait_done(800);
        start_tx();
        // EIFS after a bad FCS
        send_frame(duration_t'(20 + $urandom % 150), 1'b0, 1'b0);
        pulse_high();
        wait_done(200);
        start_tx();
        repeat (5) @(negedge clk);
        $display("errors: checks=%0d testbench=%0d", csma_checks_inst.err_cnt, tb_err);
        if (csma_checks_inst.err_cnt + tb_err == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog, 100 ns per tick with a factor of two margin
    initial begin
        #(TOTAL_TICKS * 100 * 2);
        $display("run stopped by the watchdog after %0d ticks", TOTAL_TICKS * 2);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== csma_ca.f ====
+incdir+rtl
rtl/timing_pkg.sv
rtl/frame_pkg.sv
rtl/nav_tracker.sv
rtl/slot_draw.sv
rtl/backoff_fsm.sv
rtl/csma_ca.sv
tests/csma_checks.sv
tests/tb_csma_ca.sv

// ==== Makefile ====
# Verilator build for the csma_ca channel access engine

VERILATOR ?= verilator
FILELIST  ?= csma_ca.f
TB_TOP    ?= tb_csma_ca
RTL_TOP   ?= csma_ca
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= -sv --timing --assert

RTL_SRCS = $(filter rtl/%,$(shell grep -v '^+' $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) +incdir+rtl --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
